// ==== rtl/fft_pkg.sv ====
//######################################################################
// fft engine shared types
//######################################################################
package fft_pkg;

    // largest supported frame is 2^MAX_LOG2_N points
    localparam int MAX_LOG2_N = 10;

    typedef logic signed [15:0]           sample_t;
    typedef logic [MAX_LOG2_N-1:0]        addr_t;
    // twiddle rom covers a quarter wave plus one entry
    typedef logic [MAX_LOG2_N-2:0]        tw_addr_t;
    typedef logic [MAX_LOG2_N-2:0]        tw_idx_t;

    // one data ram word, re in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        addr_t   addr_a;
        addr_t   addr_b;
        tw_idx_t tw_idx;
        logic    last;
    } bfly_cmd_t;

    typedef struct packed {
        tw_addr_t re_addr;
        logic     re_neg;
        tw_addr_t im_addr;
        logic     im_neg;
    } tw_sel_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        cplx_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_t;

endpackage

// ==== rtl/butterfly_unit.sv ====
//######################################################################
// radix-2 butterfly
//######################################################################
`timescale 1ns/1ps

module butterfly_unit (
    input  fft_pkg::cplx_t   x0,
    input  fft_pkg::cplx_t   x1,
    input  fft_pkg::sample_t w_re,
    input  fft_pkg::sample_t w_im,
    output fft_pkg::cplx_t   sum,
    output fft_pkg::cplx_t   diff
);
    import fft_pkg::*;

    logic signed [31:0] p_rr;
    logic signed [31:0] p_ii;
    logic signed [31:0] p_ri;
    logic signed [31:0] p_ir;
    logic signed [32:0] acc_re;
    logic signed [32:0] acc_im;
    sample_t            t_re;
    sample_t            t_im;
    logic signed [16:0] sum_re;
    logic signed [16:0] sum_im;
    logic signed [16:0] diff_re;
    logic signed [16:0] diff_im;

    // t = x1 * w in full precision, back to q1.15
    assign p_rr   = x1.re * w_re;
    assign p_ii   = x1.im * w_im;
    assign p_ri   = x1.re * w_im;
    assign p_ir   = x1.im * w_re;
    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;
    assign t_re   = sample_t'(acc_re >>> 15);
    assign t_im   = sample_t'(acc_im >>> 15);

    // 17 bit add and subtract
    assign sum_re  = x0.re + t_re;
    assign sum_im  = x0.im + t_im;
    assign diff_re = x0.re - t_re;
    assign diff_im = x0.im - t_im;

    // halve every stage so the frame never overflows
    assign sum.re  = sum_re[16:1];
    assign sum.im  = sum_im[16:1];
    assign diff.re = diff_re[16:1];
    assign diff.im = diff_im[16:1];

endmodule

// ==== rtl/fft_index_gen.sv ====
//######################################################################
// butterfly index generator
//######################################################################
`timescale 1ns/1ps

module fft_index_gen #(
    parameter int LOG2_N = fft_pkg::MAX_LOG2_N
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init,
    input  logic              advance,
    output fft_pkg::bfly_cmd_t cmd
);
    import fft_pkg::*;

    localparam logic [MAX_LOG2_N:0] FRAME_LEN = {{MAX_LOG2_N{1'b0}}, 1'b1} << LOG2_N;
    localparam addr_t HALF_N = addr_t'(FRAME_LEN >> 1);

    addr_t   half_step;
    addr_t   k;
    addr_t   j;
    addr_t   stride;
    tw_idx_t tw;

    logic [MAX_LOG2_N:0] next_k;
    logic                last_j;
    logic                last_k;
    logic                last_stage;

    // next group base, one bit wider so the end of frame is visible
    assign next_k     = {1'b0, k} + {half_step, 1'b0};
    assign last_j     = (j == half_step - 1'b1);
    assign last_k     = (next_k == FRAME_LEN);
    assign last_stage = (half_step == HALF_N);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_step <= addr_t'(1);
            stride    <= HALF_N;
            k         <= '0;
            j         <= '0;
            tw        <= '0;
        end else if (init) begin
            half_step <= addr_t'(1);
            stride    <= HALF_N;
            k         <= '0;
            j         <= '0;
            tw        <= '0;
        end else if (advance) begin
            if (last_j) begin
                j  <= '0;
                tw <= '0;
                if (last_k) begin
                    k <= '0;
                    // after the final stage wrap back to the first butterfly
                    if (last_stage) begin
                        half_step <= addr_t'(1);
                        stride    <= HALF_N;
                    end else begin
                        half_step <= half_step << 1;
                        stride    <= stride >> 1;
                    end
                end else begin
                    k <= next_k[MAX_LOG2_N-1:0];
                end
            end else begin
                j  <= j + 1'b1;
                // running j * stride
                tw <= tw + tw_idx_t'(stride);
            end
        end
    end

    assign cmd.addr_a = k + j;
    assign cmd.addr_b = k + j + half_step;
    assign cmd.tw_idx = tw;
    assign cmd.last   = last_j & last_k & last_stage;

endmodule

// ==== rtl/twiddle_fold.sv ====
//######################################################################
// twiddle quadrant folding
//######################################################################
`timescale 1ns/1ps

module twiddle_fold #(
    parameter int LOG2_N = fft_pkg::MAX_LOG2_N
) (
    input  logic             clk,
    input  logic             rst_n,
    input  fft_pkg::tw_idx_t tw_idx,
    output fft_pkg::tw_sel_t sel
);
    import fft_pkg::*;

    localparam logic [MAX_LOG2_N-1:0] HALF_N =
        {{(MAX_LOG2_N-1){1'b0}}, 1'b1} << (LOG2_N - 1);
    localparam logic [MAX_LOG2_N-1:0] QUARTER_N = HALF_N >> 1;

    logic [MAX_LOG2_N-1:0] idx_ext;
    tw_sel_t               sel_next;

    assign idx_ext = {1'b0, tw_idx};

    // w = cos(2*pi*i/N) - j*sin(2*pi*i/N) from a quarter wave sine rom
    always_comb begin
        // -sin is never positive over the half wave
        sel_next.im_neg = 1'b1;
        if (idx_ext <= QUARTER_N) begin
            sel_next.re_addr = tw_addr_t'(QUARTER_N - idx_ext);
            sel_next.re_neg  = 1'b0;
            sel_next.im_addr = tw_addr_t'(idx_ext);
        end else begin
            // cosine goes negative in the second quadrant
            sel_next.re_addr = tw_addr_t'(idx_ext - QUARTER_N);
            sel_next.re_neg  = 1'b1;
            sel_next.im_addr = tw_addr_t'(HALF_N - idx_ext);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= '0;
        end else begin
            sel <= sel_next;
        end
    end

endmodule

// ==== rtl/fft_sequencer.sv ====
//######################################################################
// fft sequencer and operand registers
//######################################################################
`timescale 1ns/1ps

module fft_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              clear,
    output logic              finish,
    input  fft_pkg::bfly_cmd_t cmd,
    input  fft_pkg::tw_sel_t  sel,
    output logic              init,
    output logic              advance,
    output fft_pkg::mem_req_t ram_req,
    input  fft_pkg::cplx_t    ram_rdata,
    output logic              tw_en,
    output fft_pkg::tw_addr_t tw_addr,
    input  fft_pkg::sample_t  tw_rdata
);
    import fft_pkg::*;

    localparam logic [2:0] LAST_PHASE = 3'd4;

    seq_state_t state;
    logic [2:0] phase;
    logic       last_q;
    addr_t      addr_b_q;
    cplx_t      x0;
    cplx_t      x1;
    sample_t    w_re;
    sample_t    w_im;
    cplx_t      sum;
    cplx_t      diff;

    butterfly_unit u_bfly (
        .x0   (x0),
        .x1   (x1),
        .w_re (w_re),
        .w_im (w_im),
        .sum  (sum),
        .diff (diff)
    );

    assign init = (state == IDLE) && start;
    // addr_a is done after phase 3, so the next command and its folded
    // twiddle are both settled by the following phase 0
    assign advance = (state == RUN) && (phase == 3'd3);

    // memory commands, one cycle read latency on both ports
    always_comb begin
        ram_req = '0;
        tw_en   = 1'b0;
        tw_addr = '0;
        if (state == RUN) begin
            case (phase)
                3'd0: begin
                    ram_req.en   = 1'b1;
                    ram_req.addr = cmd.addr_a;
                    tw_en        = 1'b1;
                    tw_addr      = sel.re_addr;
                end
                3'd1: begin
                    ram_req.en   = 1'b1;
                    ram_req.addr = cmd.addr_b;
                    tw_en        = 1'b1;
                    tw_addr      = sel.im_addr;
                end
                3'd3: begin
                    ram_req.en    = 1'b1;
                    ram_req.we    = 1'b1;
                    ram_req.addr  = cmd.addr_a;
                    ram_req.wdata = sum;
                end
                3'd4: begin
                    ram_req.en    = 1'b1;
                    ram_req.we    = 1'b1;
                    ram_req.addr  = addr_b_q;
                    ram_req.wdata = diff;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            phase  <= '0;
            last_q <= 1'b0;
            finish <= 1'b0;
        end else begin
            if (clear && state != DONE) begin
                finish <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= RUN;
                        phase  <= '0;
                        finish <= 1'b0;
                    end
                end
                RUN: begin
                    if (phase == 3'd1) begin
                        last_q <= cmd.last;
                    end
                    if (phase == LAST_PHASE) begin
                        phase <= '0;
                        if (last_q) begin
                            state <= DONE;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                DONE: begin
                    finish <= 1'b1;
                    state  <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // operands, rom magnitude gets its sign from the fold flags
    always_ff @(posedge clk) begin
        if (state == RUN) begin
            if (phase == 3'd1) begin
                x0       <= ram_rdata;
                w_re     <= sel.re_neg ? -tw_rdata : tw_rdata;
                addr_b_q <= cmd.addr_b;
            end
            if (phase == 3'd2) begin
                x1   <= ram_rdata;
                w_im <= sel.im_neg ? -tw_rdata : tw_rdata;
            end
        end
    end

endmodule

// ==== rtl/fft_core.sv ====
//######################################################################
// fft engine top level
//######################################################################
`timescale 1ns/1ps

module fft_core #(
    parameter int LOG2_N = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              clear,
    output logic              finish,
    output fft_pkg::mem_req_t ram_req,
    input  fft_pkg::cplx_t    ram_rdata,
    output logic              tw_en,
    output fft_pkg::tw_addr_t tw_addr,
    input  fft_pkg::sample_t  tw_rdata
);
    import fft_pkg::*;

    bfly_cmd_t cmd;
    tw_sel_t   sel;
    logic      init;
    logic      advance;

    fft_index_gen #(
        .LOG2_N (LOG2_N)
    ) u_index_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .init    (init),
        .advance (advance),
        .cmd     (cmd)
    );

    twiddle_fold #(
        .LOG2_N (LOG2_N)
    ) u_twiddle_fold (
        .clk    (clk),
        .rst_n  (rst_n),
        .tw_idx (cmd.tw_idx),
        .sel    (sel)
    );

    fft_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .clear     (clear),
        .finish    (finish),
        .cmd       (cmd),
        .sel       (sel),
        .init      (init),
        .advance   (advance),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .tw_en     (tw_en),
        .tw_addr   (tw_addr),
        .tw_rdata  (tw_rdata)
    );

endmodule

// ==== verif/tb_clock.sv ====
//######################################################################
// testbench clock
//######################################################################
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// ==== verif/fft_properties.sv ====
//######################################################################
// sequencer memory port assertions
//######################################################################
`timescale 1ns/1ps

module fft_properties (
    input logic                clk,
    input logic                rst_n,
    input fft_pkg::seq_state_t state,
    input fft_pkg::mem_req_t   ram_req,
    input logic                tw_en,
    input logic                finish
);
    import fft_pkg::*;

    // a write always comes with the enable
    a_we_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        ram_req.we |-> ram_req.en)
        else $error("ram write strobe without ram enable");

    // memories are quiet unless a transform runs
    a_quiet_outside_run: assert property (@(posedge clk) disable iff (!rst_n)
        (state != RUN) |-> !(ram_req.en || tw_en))
        else $error("memory enable high outside the run state");

    a_finish_no_ram: assert property (@(posedge clk) disable iff (!rst_n)
        !(finish && ram_req.en))
        else $error("finish and ram enable high together");

endmodule

bind fft_sequencer fft_properties u_properties (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .ram_req (ram_req),
    .tw_en   (tw_en),
    .finish  (finish)
);

// ==== verif/fft_tb.sv ====
//######################################################################
// fft engine testbench
//######################################################################
`timescale 1ns/1ps

module fft_tb;
    import fft_pkg::*;

    localparam int  LOG2_N  = 10;
    localparam int  N       = 1 << LOG2_N;
    localparam int  TIMEOUT = 40000;
    localparam real PI      = 3.14159265358979;

    logic     clk;
    logic     rst_n;
    logic     start;
    logic     clear;
    logic     finish;
    mem_req_t ram_req;
    cplx_t    ram_rdata = '0;
    logic     tw_en;
    tw_addr_t tw_addr;
    sample_t  tw_rdata = '0;

    cplx_t   mem   [0:N-1];
    cplx_t   model [0:N-1];
    sample_t rom   [0:N/4];
    integer  seed;
    int      errors       = 0;
    int      finish_rises = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    fft_core #(
        .LOG2_N (LOG2_N)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .clear     (clear),
        .finish    (finish),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .tw_en     (tw_en),
        .tw_addr   (tw_addr),
        .tw_rdata  (tw_rdata)
    );

    // data ram and twiddle rom with one cycle read latency
    always @(posedge clk) begin
        if (ram_req.en) begin
            if (ram_req.we) begin
                mem[ram_req.addr] <= ram_req.wdata;
            end else begin
                ram_rdata <= mem[ram_req.addr];
            end
        end
        if (tw_en) begin
            tw_rdata <= rom[tw_addr];
        end
    end

    always @(posedge finish) begin
        finish_rises = finish_rises + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // w = cos - j*sin built from the quarter wave
    function automatic cplx_t twiddle(input int i);
        cplx_t w;
        if (i <= N/4) begin
            w.re = rom[N/4 - i];
            w.im = -rom[i];
        end else begin
            w.re = -rom[i - N/4];
            w.im = -rom[N/2 - i];
        end
        return w;
    endfunction

    function automatic sample_t halve(input int v);
        return sample_t'(v >>> 1);
    endfunction

    // in-place radix-2 dit over the model array
    task automatic run_model();
        int      half;
        int      stride;
        cplx_t   w;
        cplx_t   x0;
        cplx_t   x1;
        longint  acc_re;
        longint  acc_im;
        sample_t t_re;
        sample_t t_im;
        half   = 1;
        stride = N/2;
        while (half < N) begin
            for (int k = 0; k < N; k += 2*half) begin
                for (int j = 0; j < half; j++) begin
                    x0     = model[k+j];
                    x1     = model[k+j+half];
                    w      = twiddle(j*stride);
                    acc_re = longint'(x1.re) * longint'(w.re) - longint'(x1.im) * longint'(w.im);
                    acc_im = longint'(x1.re) * longint'(w.im) + longint'(x1.im) * longint'(w.re);
                    t_re   = sample_t'(acc_re >>> 15);
                    t_im   = sample_t'(acc_im >>> 15);
                    model[k+j].re      = halve(int'(x0.re) + int'(t_re));
                    model[k+j].im      = halve(int'(x0.im) + int'(t_im));
                    model[k+j+half].re = halve(int'(x0.re) - int'(t_re));
                    model[k+j+half].im = halve(int'(x0.im) - int'(t_im));
                end
            end
            half   = half * 2;
            stride = stride / 2;
        end
    endtask

    task automatic load_random_frame();
        cplx_t v;
        for (int a = 0; a < N; a++) begin
            v.re     = sample_t'($random(seed) % 8192);
            v.im     = sample_t'($random(seed) % 8192);
            mem[a]   <= v;
            model[a] = v;
        end
        run_model();
    endtask

    task automatic load_impulse();
        for (int a = 0; a < N; a++) begin
            mem[a]   <= (a == 0) ? {16'sd8192, 16'sd0} : '0;
            model[a] = (a == 0) ? {16'sd8192, 16'sd0} : '0;
        end
        run_model();
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_finish(input string name);
        int cycles;
        cycles = 0;
        while (finish !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("timeout, %s never raised finish", name));
            end
        end
    endtask

    task automatic compare_frame(input string name);
        for (int a = 0; a < N; a++) begin
            check_value($sformatf("%s word %0d", name, a), model[a], mem[a]);
        end
    endtask

    initial begin
        seed  = 32'he7010a64;
        rst_n = 1'b0;
        start = 1'b0;
        clear = 1'b0;
        for (int m = 0; m <= N/4; m++) begin
            rom[m] = sample_t'($rtoi($sin(2.0 * PI * m / N) * 32767.0 + 0.5));
        end

        // reset state
        repeat (10) begin
            @(negedge clk);
            check_value("reset", 32'h0, 32'({finish, ram_req.en, ram_req.we, tw_en}));
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("after reset", 32'h0, 32'({finish, ram_req.en, ram_req.we, tw_en}));
        end

        load_random_frame();
        pulse_start();
        wait_finish("full transform");
        compare_frame("full transform");

        // impulse spreads to a flat spectrum
        load_impulse();
        pulse_start();
        wait_finish("impulse");
        compare_frame("impulse");
        for (int a = 0; a < N; a++) begin
            check_value($sformatf("impulse flat %0d", a),
                        {16'(8192 >>> LOG2_N), 16'h0}, mem[a]);
        end

        // second start during run must be ignored
        load_random_frame();
        finish_rises = 0;
        pulse_start();
        repeat (200) @(negedge clk);
        check_value("busy finish low", 32'h0, 32'(finish));
        pulse_start();
        wait_finish("start while busy");
        compare_frame("start while busy");
        repeat (20) begin
            @(negedge clk);
            check_value("busy idle after", 32'h2, 32'({finish, ram_req.en}));
        end
        check_value("finish rises", 32'd1, 32'(finish_rises));

        // finish holds until clear
        repeat (30) begin
            @(negedge clk);
            check_value("finish hold", 32'h1, 32'(finish));
        end
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        check_value("finish cleared", 32'h0, 32'(finish));
        load_random_frame();
        pulse_start();
        wait_finish("second frame");
        compare_frame("second frame");

        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/fft_pkg.sv
rtl/butterfly_unit.sv
rtl/fft_index_gen.sv
rtl/twiddle_fold.sv
rtl/fft_sequencer.sv
rtl/fft_core.sv
verif/tb_clock.sv
verif/fft_properties.sv
verif/fft_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fft_tb -f list.f -o fft_sim

output=$(./obj_dir/fft_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
